// File: design/lc4_isa_pkg.sv
`default_nettype none

package lc4_isa_pkg;

  typedef logic [15:0] word_t;     // one machine word
  typedef logic [2:0]  reg_sel_t;  // r0..r7
  typedef logic [2:0]  nzp_t;      // {n, z, p}

  // major opcodes, insn[15:12]
  localparam logic [3:0] OP_BR    = 4'b0000;
  localparam logic [3:0] OP_ARITH = 4'b0001;
  localparam logic [3:0] OP_AND   = 4'b0101;
  localparam logic [3:0] OP_LDR   = 4'b0110;
  localparam logic [3:0] OP_STR   = 4'b0111;
  localparam logic [3:0] OP_CONST = 4'b1001;

  localparam logic [2:0] SUB_ADD = 3'b000;  // insn[5:3] of ARITH
  localparam logic [2:0] SUB_SUB = 3'b010;
  localparam logic [2:0] SUB_AND = 3'b000;  // register form of AND

  // field lsb positions
  localparam int F_OP  = 12;
  localparam int F_RD  = 9;   // rd, rt of STR, nzp mask of BR
  localparam int F_RS  = 6;
  localparam int F_SUB = 3;
  localparam int F_RT  = 0;
  localparam int F_IMM = 5;   // set for ADD with imm5

  localparam word_t NOP_INSN = 16'h0000;  // BR with empty mask, never taken

  // ADDR is base plus immediate, shared by LDR, STR and ADD imm5
  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_PASS_IMM, ALU_ADDR} alu_op_t;

  typedef struct packed {
    reg_sel_t r1sel;
    logic     r1re;
    reg_sel_t r2sel;
    logic     r2re;
    reg_sel_t wsel;
    logic     regfile_we;
    logic     nzp_we;
    logic     is_load;
    logic     is_store;
    logic     is_branch;
    nzp_t     br_mask;
    alu_op_t  alu_op;
    word_t    imm;       // already sign extended
  } ctrl_t;

  // condition code of a result word
  function automatic nzp_t nzp_of(word_t w);
    return {w[15], w == '0, !w[15] && (w != '0)};
  endfunction

endpackage

`default_nettype wire

// File: design/lc4_pipe_pkg.sv
`default_nettype none

package lc4_pipe_pkg;

  import lc4_isa_pkg::*;

  typedef logic [1:0] stall_t;  // trace stall code

  localparam stall_t STALL_NONE  = 2'd0;
  localparam stall_t STALL_FLUSH = 2'd2;  // reset and flush bubbles

  localparam word_t RESET_PC = 16'h8200;

  // decode -> execute
  typedef struct packed {
    word_t  pc;
    word_t  insn;
    ctrl_t  ctrl;
    word_t  rs_data;  // regfile read, before bypass
    word_t  rt_data;
    stall_t stall;
  } dx_t;

  // execute -> memory
  typedef struct packed {
    word_t    pc;
    word_t    insn;
    reg_sel_t wsel;
    logic     regfile_we;
    logic     nzp_we;
    logic     is_load;
    logic     is_store;
    word_t    alu;      // result, or address for loads and stores
    word_t    st_data;
    nzp_t     nzp;      // from alu, redone at writeback for loads
    stall_t   stall;
  } xm_t;

endpackage

`default_nettype wire

// File: design/lc4_wb_if.sv
`timescale 1ns/1ps
`default_nettype none

// writeback result as seen by the regfile and the execute bypass
interface lc4_wb_if
  import lc4_isa_pkg::*;
();

  reg_sel_t wsel;     // destination register
  logic     we;       // regfile write this cycle
  word_t    data;     // value being written
  logic     nzp_we;
  nzp_t     nzp;      // new condition bits
  nzp_t     cur_nzp;  // nzp register contents

  modport wb_src  (output wsel, we, data, nzp_we, nzp, cur_nzp);
  modport wb_sink (input  wsel, we, data, nzp_we, nzp, cur_nzp);

endinterface

`default_nettype wire

// File: design/lc4_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_fetch
  import lc4_isa_pkg::*, lc4_pipe_pkg::*;
(
  input  wire         gwe,
  input  wire         i_reset,
  input  wire         i_flush,   // taken branch in execute
  input  wire word_t  i_target,
  input  wire word_t  i_insn,    // imem word at o_pc
  output word_t       o_pc,
  output word_t       o_d_pc,
  output word_t       o_d_insn,
  output stall_t      o_d_stall
);

  word_t pc_q;

  always_ff @(posedge gwe) begin
    if (i_reset) pc_q <= RESET_PC;
    else pc_q <= i_flush ? i_target : pc_q + 16'd1;  // redirect wins over sequential
  end

  assign o_pc = pc_q;

  // fetch -> decode, the fetched word dies on a flush
  always_ff @(posedge gwe) begin
    if (i_reset || i_flush) begin
      o_d_insn  <= NOP_INSN;
      o_d_stall <= STALL_FLUSH;
    end else begin
      o_d_insn  <= i_insn;
      o_d_stall <= STALL_NONE;
    end
  end

  always_ff @(posedge gwe) o_d_pc <= pc_q;  // payload only

endmodule

`default_nettype wire

// File: design/lc4_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_decoder
  import lc4_isa_pkg::*;
(
  input  wire word_t i_insn,
  output ctrl_t      o_ctrl
);

  logic [2:0] sub;
  logic       wr;     // writes rd and nzp

  assign sub = i_insn[F_SUB +: 3];

  always_comb begin
    o_ctrl        = '0;         // no writes, no memory access
    o_ctrl.alu_op = ALU_ADD;
    wr            = 1'b0;
    o_ctrl.r1sel  = i_insn[F_RS +: 3];
    o_ctrl.r2sel  = i_insn[F_RT +: 3];
    case (i_insn[F_OP +: 4])
      OP_BR: begin
        o_ctrl.br_mask   = i_insn[F_RD +: 3];
        o_ctrl.is_branch = |i_insn[F_RD +: 3];  // empty mask is a nop
        o_ctrl.imm       = {{7{i_insn[8]}}, i_insn[8:0]};
      end
      OP_ARITH: begin
        if (i_insn[F_IMM]) begin                // ADD rd, rs, imm5
          o_ctrl.r1re   = 1'b1;
          o_ctrl.alu_op = ALU_ADDR;
          o_ctrl.imm    = {{11{i_insn[4]}}, i_insn[4:0]};
          wr            = 1'b1;
        end else if (sub == SUB_ADD || sub == SUB_SUB) begin
          o_ctrl.r1re   = 1'b1;
          o_ctrl.r2re   = 1'b1;
          o_ctrl.alu_op = (sub == SUB_SUB) ? ALU_SUB : ALU_ADD;
          wr            = 1'b1;
        end                                     // MUL, DIV left as nop
      end
      OP_AND: begin
        if (sub == SUB_AND) begin
          o_ctrl.r1re   = 1'b1;
          o_ctrl.r2re   = 1'b1;
          o_ctrl.alu_op = ALU_AND;
          wr            = 1'b1;
        end
      end
      OP_LDR: begin
        o_ctrl.r1re    = 1'b1;                  // base
        o_ctrl.is_load = 1'b1;
        o_ctrl.alu_op  = ALU_ADDR;
        o_ctrl.imm     = {{10{i_insn[5]}}, i_insn[5:0]};
        wr             = 1'b1;
      end
      OP_STR: begin
        o_ctrl.r1re     = 1'b1;
        o_ctrl.r2sel    = i_insn[F_RD +: 3];    // data comes from the rd field
        o_ctrl.r2re     = 1'b1;
        o_ctrl.is_store = 1'b1;
        o_ctrl.alu_op   = ALU_ADDR;
        o_ctrl.imm      = {{10{i_insn[5]}}, i_insn[5:0]};
      end
      OP_CONST: begin
        o_ctrl.alu_op = ALU_PASS_IMM;
        o_ctrl.imm    = {{7{i_insn[8]}}, i_insn[8:0]};
        wr            = 1'b1;
      end
      default: ;                                // unsupported, nop
    endcase
    o_ctrl.wsel       = i_insn[F_RD +: 3];
    o_ctrl.regfile_we = wr;
    o_ctrl.nzp_we     = wr;                     // every rd write sets nzp
  end

endmodule

`default_nettype wire

// File: design/lc4_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_regfile
  import lc4_isa_pkg::*;
(
  input  wire        gwe,
  input  wire        i_reset,
  input  wire reg_sel_t i_rs,
  input  wire reg_sel_t i_rt,
  output word_t      o_rs_data,
  output word_t      o_rt_data,
  lc4_wb_if.wb_sink  wb
);

  word_t regs [8];

  always_ff @(posedge gwe) begin
    if (i_reset) regs <= '{default: '0};
    else if (wb.we) regs[wb.wsel] <= wb.data;
  end

  // write-through, decode sees the value retiring this cycle
  assign o_rs_data = (wb.we && wb.wsel == i_rs) ? wb.data : regs[i_rs];
  assign o_rt_data = (wb.we && wb.wsel == i_rt) ? wb.data : regs[i_rt];

endmodule

`default_nettype wire

// File: design/lc4_execute.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_execute
  import lc4_isa_pkg::*, lc4_pipe_pkg::*;
(
  input  wire         gwe,
  input  wire         i_reset,
  input  wire word_t  i_d_pc,
  input  wire word_t  i_d_insn,
  input  wire stall_t i_d_stall,
  input  wire ctrl_t  i_ctrl,
  input  wire word_t  i_rs_data,
  input  wire word_t  i_rt_data,
  lc4_wb_if.wb_sink   wb,
  output logic        o_flush,   // taken branch, kill the two younger insns
  output word_t       o_target,
  output xm_t         o_xm
);

  dx_t   dx_q;
  xm_t   xm_q;
  word_t a;        // bypassed rs
  word_t b;        // bypassed rt, also store data
  word_t alu;
  nzp_t  br_nzp;   // youngest nzp in flight

  // memory stage first since it is younger than writeback
  function automatic word_t bypass(reg_sel_t sel, logic re, word_t rf);
    if (re && xm_q.regfile_we && xm_q.wsel == sel) return xm_q.alu;
    if (re && wb.we && wb.wsel == sel) return wb.data;
    return rf;
  endfunction

  // decode -> execute, flushed insn becomes a bubble
  always_ff @(posedge gwe) begin
    if (i_reset || o_flush) begin
      dx_q       <= '0;
      dx_q.insn  <= NOP_INSN;
      dx_q.stall <= STALL_FLUSH;
    end else begin
      dx_q <= '{pc: i_d_pc, insn: i_d_insn, ctrl: i_ctrl,
                rs_data: i_rs_data, rt_data: i_rt_data, stall: i_d_stall};
    end
  end

  always_comb begin
    a = bypass(dx_q.ctrl.r1sel, dx_q.ctrl.r1re, dx_q.rs_data);
    b = bypass(dx_q.ctrl.r2sel, dx_q.ctrl.r2re, dx_q.rt_data);
  end

  always_comb begin
    case (dx_q.ctrl.alu_op)
      ALU_ADD:      alu = a + b;
      ALU_SUB:      alu = a - b;
      ALU_AND:      alu = a & b;
      ALU_PASS_IMM: alu = dx_q.ctrl.imm;     // CONST
      ALU_ADDR:     alu = a + dx_q.ctrl.imm;
      default:      alu = '0;
    endcase
  end

  // a load in memory still carries its address here, programs keep a gap
  always_comb begin
    if (xm_q.nzp_we) br_nzp = xm_q.nzp;
    else if (wb.nzp_we) br_nzp = wb.nzp;
    else br_nzp = wb.cur_nzp;
  end

  assign o_flush  = dx_q.ctrl.is_branch && |(dx_q.ctrl.br_mask & br_nzp);
  assign o_target = dx_q.pc + 16'd1 + dx_q.ctrl.imm;

  // execute -> memory
  always_ff @(posedge gwe) begin
    if (i_reset) begin
      xm_q       <= '0;
      xm_q.insn  <= NOP_INSN;
      xm_q.stall <= STALL_FLUSH;
    end else begin
      xm_q.pc         <= dx_q.pc;
      xm_q.insn       <= dx_q.insn;
      xm_q.wsel       <= dx_q.ctrl.wsel;
      xm_q.regfile_we <= dx_q.ctrl.regfile_we;
      xm_q.nzp_we     <= dx_q.ctrl.nzp_we;
      xm_q.is_load    <= dx_q.ctrl.is_load;
      xm_q.is_store   <= dx_q.ctrl.is_store;
      xm_q.alu        <= alu;
      xm_q.st_data    <= b;
      xm_q.nzp        <= nzp_of(alu);
      xm_q.stall      <= dx_q.stall;
    end
  end

  assign o_xm = xm_q;

endmodule

`default_nettype wire

// File: design/lc4_mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_mem_wb
  import lc4_isa_pkg::*, lc4_pipe_pkg::*;
(
  input  wire         gwe,
  input  wire         i_reset,
  input  wire xm_t    i_xm,
  input  wire word_t  i_dmem_data,      // same-cycle read of o_dmem_addr
  output word_t       o_dmem_addr,
  output logic        o_dmem_we,
  output word_t       o_dmem_towrite,
  lc4_wb_if.wb_src    wb,
  output stall_t      o_test_stall,
  output word_t       o_test_pc,
  output word_t       o_test_insn,
  output logic        o_test_regfile_we,
  output reg_sel_t    o_test_regfile_wsel,
  output word_t       o_test_regfile_data,
  output logic        o_test_nzp_we,
  output nzp_t        o_test_nzp_bits
);

  xm_t   w_q;
  word_t ld_q;     // loaded word
  word_t result;
  nzp_t  w_nzp;
  nzp_t  nzp_q;    // architectural nzp

  // memory port, zero when idle
  assign o_dmem_addr    = (i_xm.is_load || i_xm.is_store) ? i_xm.alu : '0;
  assign o_dmem_we      = i_xm.is_store;
  assign o_dmem_towrite = i_xm.is_store ? i_xm.st_data : '0;

  always_ff @(posedge gwe) begin
    if (i_reset) begin
      w_q       <= '0;
      w_q.insn  <= NOP_INSN;
      w_q.stall <= STALL_FLUSH;
    end else begin
      w_q <= i_xm;
    end
  end

  always_ff @(posedge gwe) ld_q <= i_dmem_data;

  assign result = w_q.is_load ? ld_q : w_q.alu;
  assign w_nzp  = w_q.is_load ? nzp_of(ld_q) : w_q.nzp;  // loads set nzp too

  always_ff @(posedge gwe) begin
    if (i_reset) nzp_q <= '0;
    else if (w_q.nzp_we) nzp_q <= w_nzp;
  end

  assign wb.wsel    = w_q.wsel;
  assign wb.we      = w_q.regfile_we;
  assign wb.data    = result;
  assign wb.nzp_we  = w_q.nzp_we;
  assign wb.nzp     = w_nzp;
  assign wb.cur_nzp = nzp_q;

  // retire trace
  assign o_test_stall        = w_q.stall;
  assign o_test_pc           = w_q.pc;
  assign o_test_insn         = w_q.insn;
  assign o_test_regfile_we   = w_q.regfile_we;
  assign o_test_regfile_wsel = w_q.wsel;
  assign o_test_regfile_data = result;
  assign o_test_nzp_we       = w_q.nzp_we;
  assign o_test_nzp_bits     = w_nzp;

endmodule

`default_nettype wire

// File: design/lc4_processor.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_processor
  import lc4_isa_pkg::*, lc4_pipe_pkg::*;
(
  input  wire         gwe,                 // pipeline clock
  input  wire         i_reset,
  output word_t       o_cur_pc,            // imem address
  input  wire word_t  i_cur_insn,
  output word_t       o_dmem_addr,
  input  wire word_t  i_cur_dmem_data,
  output logic        o_dmem_we,
  output word_t       o_dmem_towrite,
  output stall_t      o_test_stall,        // 0 real insn, 2 bubble
  output word_t       o_test_pc,
  output word_t       o_test_insn,
  output logic        o_test_regfile_we,
  output reg_sel_t    o_test_regfile_wsel,
  output word_t       o_test_regfile_data,
  output logic        o_test_nzp_we,
  output nzp_t        o_test_nzp_bits
);

  logic   flush;
  word_t  target;
  word_t  d_pc, d_insn;
  stall_t d_stall;
  ctrl_t  ctrl;
  word_t  rs_data, rt_data;
  xm_t    xm;

  lc4_wb_if wb ();

  lc4_fetch u_fetch (.gwe, .i_reset, .i_flush(flush), .i_target(target), .i_insn(i_cur_insn),
                     .o_pc(o_cur_pc), .o_d_pc(d_pc), .o_d_insn(d_insn), .o_d_stall(d_stall));

  lc4_decoder u_dec (.i_insn(d_insn), .o_ctrl(ctrl));

  lc4_regfile u_rf (.gwe, .i_reset, .i_rs(ctrl.r1sel), .i_rt(ctrl.r2sel),
                    .o_rs_data(rs_data), .o_rt_data(rt_data), .wb(wb.wb_sink));

  lc4_execute u_ex (.gwe, .i_reset, .i_d_pc(d_pc), .i_d_insn(d_insn), .i_d_stall(d_stall),
                    .i_ctrl(ctrl), .i_rs_data(rs_data), .i_rt_data(rt_data), .wb(wb.wb_sink),
                    .o_flush(flush), .o_target(target), .o_xm(xm));

  lc4_mem_wb u_mw (.gwe, .i_reset, .i_xm(xm), .i_dmem_data(i_cur_dmem_data),
                   .o_dmem_addr, .o_dmem_we, .o_dmem_towrite, .wb(wb.wb_src),
                   .o_test_stall, .o_test_pc, .o_test_insn, .o_test_regfile_we,
                   .o_test_regfile_wsel, .o_test_regfile_data, .o_test_nzp_we,
                   .o_test_nzp_bits);

endmodule

`default_nettype wire

// File: testbench/lc4_chk.sv
`timescale 1ns/1ps
`default_nettype none

// pipeline invariants, bound into the processor top
module lc4_chk
  import lc4_isa_pkg::*, lc4_pipe_pkg::*;
(
  input wire         gwe,
  input wire         i_reset,
  input wire word_t  i_cur_pc,
  input wire         i_dmem_we,
  input wire word_t  i_dmem_addr,
  input wire stall_t i_mem_stall,    // stall code of the insn in memory
  input wire stall_t i_test_stall,   // stall code at writeback
  input wire         i_regfile_we,
  input wire         i_nzp_we
);

  int fail_count = 0;  // read by the testbench at the end

  // only a real insn stores, and to a known address
  a_store_real: assert property (@(posedge gwe) disable iff (i_reset)
    i_dmem_we |-> (i_mem_stall == STALL_NONE && !$isunknown(i_dmem_addr)))
    else begin
      fail_count++;
      $error("store issued by a bubble or to an unknown address");
    end

  // bubbles write nothing
  a_bubble_quiet: assert property (@(posedge gwe) disable iff (i_reset)
    (i_test_stall == STALL_FLUSH) |-> (!i_regfile_we && !i_nzp_we))
    else begin
      fail_count++;
      $error("bubble at writeback writes the regfile or nzp");
    end

  a_reset_pc: assert property (@(posedge gwe) i_reset |=> (i_cur_pc == RESET_PC))
    else begin
      fail_count++;
      $error("pc is not the reset pc after reset");
    end

endmodule

bind lc4_processor lc4_chk u_chk (
  .gwe(gwe),
  .i_reset(i_reset),
  .i_cur_pc(o_cur_pc),
  .i_dmem_we(o_dmem_we),
  .i_dmem_addr(o_dmem_addr),
  .i_mem_stall(xm.stall),           // memory stage payload inside the top
  .i_test_stall(o_test_stall),
  .i_regfile_we(o_test_regfile_we),
  .i_nzp_we(o_test_nzp_we)
);

`default_nettype wire

// File: testbench/lc4_monitor.sv
`timescale 1ns/1ps
`default_nettype none

// compares each retired insn against the next expected record
module lc4_monitor
  import lc4_isa_pkg::*, lc4_pipe_pkg::*;
(
  input  wire           gwe,
  input  wire           i_reset,
  input  wire stall_t   i_test_stall,
  input  wire word_t    i_test_pc,
  input  wire word_t    i_test_insn,
  input  wire           i_test_regfile_we,
  input  wire reg_sel_t i_test_regfile_wsel,
  input  wire word_t    i_test_regfile_data,
  input  wire           i_test_nzp_we,
  input  wire nzp_t     i_test_nzp_bits,
  output int            o_retired,
  output int            o_errors,
  output logic          o_done      // every expected insn has retired
);

  word_t    exp_pc     [32];
  word_t    exp_insn   [32];
  logic     exp_we     [32];
  reg_sel_t exp_wsel   [32];
  word_t    exp_data   [32];
  logic     exp_nzp_we [32];
  nzp_t     exp_nzp    [32];
  int       exp_count = 0;
  int       next_idx  = 0;
  int       n_retired = 0;
  int       n_errors  = 0;
  logic     row_bad;

  assign o_retired = n_retired;
  assign o_errors  = n_errors;
  assign o_done    = (exp_count != 0) && (next_idx == exp_count);

  // called by the testbench while it loads the program
  task automatic add_expected(input word_t pc, input word_t insn, input logic we,
                              input reg_sel_t wsel, input word_t data, input logic nzp_we,
                              input nzp_t nzp);
    exp_pc[exp_count]     = pc;
    exp_insn[exp_count]   = insn;
    exp_we[exp_count]     = we;
    exp_wsel[exp_count]   = wsel;
    exp_data[exp_count]   = data;
    exp_nzp_we[exp_count] = nzp_we;
    exp_nzp[exp_count]    = nzp;
    exp_count             = exp_count + 1;
  endtask

  task automatic compare_field(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h at pc %h", name, got, exp, exp_pc[next_idx]);
      row_bad = 1'b1;
    end
  endtask

  // trace outputs have settled by the falling edge
  always @(negedge gwe) begin
    // bubbles carry code 2 and real insns code 0
    if (!i_reset && i_test_stall !== STALL_NONE && i_test_stall !== STALL_FLUSH) begin
      $display("Mismatch o_test_stall: got %h expected %h", i_test_stall, STALL_FLUSH);
      n_errors = n_errors + 1;
    end
    if (!i_reset && !o_done && i_test_stall == STALL_NONE) begin
      row_bad = 1'b0;
      if (i_test_pc !== exp_pc[next_idx]) begin  // flushed insn retired or one went missing
        $display("unexpected instruction retired at pc %h while pc %h was due",
                 i_test_pc, exp_pc[next_idx]);
        row_bad = 1'b1;
      end else begin
        compare_field("o_test_insn", i_test_insn, exp_insn[next_idx]);
        compare_field("o_test_regfile_we", 16'(i_test_regfile_we), 16'(exp_we[next_idx]));
        compare_field("o_test_nzp_we", 16'(i_test_nzp_we), 16'(exp_nzp_we[next_idx]));
        if (exp_we[next_idx]) begin              // wsel and data only matter on a write
          compare_field("o_test_regfile_wsel", 16'(i_test_regfile_wsel),
                        16'(exp_wsel[next_idx]));
          compare_field("o_test_regfile_data", i_test_regfile_data, exp_data[next_idx]);
        end
        if (exp_nzp_we[next_idx])
          compare_field("o_test_nzp_bits", 16'(i_test_nzp_bits), 16'(exp_nzp[next_idx]));
      end
      if (row_bad) n_errors = n_errors + 1;
      $display("retire pc %h insn %h: %s", i_test_pc, i_test_insn, row_bad ? "FAIL" : "ok");
      n_retired = n_retired + 1;
      next_idx  = next_idx + 1;
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_lc4.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lc4
  import lc4_isa_pkg::*, lc4_pipe_pkg::*;
();

  logic     gwe = 1'b0;
  logic     i_reset;
  word_t    o_cur_pc, i_cur_insn, o_dmem_addr, i_cur_dmem_data, o_dmem_towrite;
  logic     o_dmem_we, o_test_regfile_we, o_test_nzp_we;
  stall_t   o_test_stall;
  word_t    o_test_pc, o_test_insn, o_test_regfile_data;
  reg_sel_t o_test_regfile_wsel;
  nzp_t     o_test_nzp_bits;

  // program table with one row per insn and its retire record
  word_t    prog_insn    [32];
  logic     prog_flushed [32];   // killed by a taken branch so it never retires
  logic     exp_we       [32];
  reg_sel_t exp_wsel     [32];
  word_t    exp_data     [32];
  logic     exp_nzp_we   [32];
  nzp_t     exp_nzp      [32];
  int       prog_len = 0;

  word_t imem [32];
  word_t dmem [16];
  word_t imem_idx;
  int    cycles = 0;
  int    limit;
  int    retired, errors;
  logic  done;

  always #4 gwe = ~gwe;  // 8 ns period
  always @(posedge gwe) cycles <= cycles + 1;
  always @(posedge gwe) if (o_dmem_we) dmem[o_dmem_addr[3:0]] <= o_dmem_towrite;

  // combinational memories that return a nop outside the program
  assign imem_idx        = o_cur_pc - RESET_PC;
  assign i_cur_insn      = (imem_idx < prog_len) ? imem[imem_idx[4:0]] : NOP_INSN;
  assign i_cur_dmem_data = dmem[o_dmem_addr[3:0]];

  lc4_processor DUT (.gwe, .i_reset, .o_cur_pc, .i_cur_insn, .o_dmem_addr, .i_cur_dmem_data,
                     .o_dmem_we, .o_dmem_towrite, .o_test_stall, .o_test_pc, .o_test_insn,
                     .o_test_regfile_we, .o_test_regfile_wsel, .o_test_regfile_data,
                     .o_test_nzp_we, .o_test_nzp_bits);

  lc4_monitor u_mon (.gwe, .i_reset, .i_test_stall(o_test_stall), .i_test_pc(o_test_pc),
                     .i_test_insn(o_test_insn), .i_test_regfile_we(o_test_regfile_we),
                     .i_test_regfile_wsel(o_test_regfile_wsel),
                     .i_test_regfile_data(o_test_regfile_data), .i_test_nzp_we(o_test_nzp_we),
                     .i_test_nzp_bits(o_test_nzp_bits), .o_retired(retired), .o_errors(errors),
                     .o_done(done));

  // small assembler
  function automatic word_t enc_const(reg_sel_t rd, logic [8:0] imm9);
    return {OP_CONST, rd, imm9};
  endfunction
  function automatic word_t enc_rrr(logic [3:0] op, reg_sel_t rd, reg_sel_t rs,
                                    logic [2:0] sub, reg_sel_t rt);
    return {op, rd, rs, sub, rt};
  endfunction
  function automatic word_t enc_addi(reg_sel_t rd, reg_sel_t rs, logic [4:0] imm5);
    return {OP_ARITH, rd, rs, 1'b1, imm5};
  endfunction
  function automatic word_t enc_mem(logic [3:0] op, reg_sel_t r, reg_sel_t base,
                                    logic [5:0] off6);
    return {op, r, base, off6};  // r is rd of LDR and the data reg of STR
  endfunction
  function automatic word_t enc_br(nzp_t mask, logic [8:0] off9);
    return {OP_BR, mask, off9};
  endfunction

  task automatic add_row(input word_t insn, input logic flushed, input logic we,
                         input reg_sel_t wsel, input word_t data, input logic nzp_we,
                         input nzp_t nzp);
    prog_insn[prog_len]    = insn;
    prog_flushed[prog_len] = flushed;
    exp_we[prog_len]       = we;
    exp_wsel[prog_len]     = wsel;
    exp_data[prog_len]     = data;
    exp_nzp_we[prog_len]   = nzp_we;
    exp_nzp[prog_len]      = nzp;
    prog_len               = prog_len + 1;
  endtask

  initial begin
    int i;
    i_reset = 1'b1;
    for (i = 0; i < 16; i++) dmem[i] = 16'ha500 + 16'(i) * 16'h0111;
    //      insn                                   flush we wsel data     nzpwe nzp
    add_row(enc_const(3'd1, 9'd5),                  0, 1, 3'd1, 16'h0005, 1, 3'b001);
    add_row(enc_const(3'd2, 9'h1fd),                0, 1, 3'd2, 16'hfffd, 1, 3'b100);
    add_row(enc_rrr(OP_ARITH, 3'd3, 3'd1, SUB_ADD, 3'd2), 0, 1, 3'd3, 16'h0002, 1, 3'b001);
    add_row(enc_rrr(OP_ARITH, 3'd4, 3'd3, SUB_SUB, 3'd1), 0, 1, 3'd4, 16'hfffd, 1, 3'b100);
    add_row(enc_rrr(OP_AND, 3'd5, 3'd4, 3'b000, 3'd3),    0, 1, 3'd5, 16'h0000, 1, 3'b010);
    add_row(enc_addi(3'd6, 3'd5, 5'h1f),            0, 1, 3'd6, 16'hffff, 1, 3'b100);
    add_row(enc_rrr(OP_ARITH, 3'd7, 3'd6, SUB_SUB, 3'd6), 0, 1, 3'd7, 16'h0000, 1, 3'b010);
    add_row(enc_addi(3'd1, 3'd1, 5'd15),            0, 1, 3'd1, 16'h0014, 1, 3'b001);
    add_row(enc_const(3'd2, 9'd3),                  0, 1, 3'd2, 16'h0003, 1, 3'b001);
    add_row(enc_mem(OP_STR, 3'd6, 3'd2, 6'd4),      0, 0, 3'd0, 16'h0000, 0, 3'b000);
    add_row(enc_const(3'd3, 9'd1),                  0, 1, 3'd3, 16'h0001, 1, 3'b001);
    add_row(enc_mem(OP_LDR, 3'd4, 3'd0, 6'd7),      0, 1, 3'd4, 16'hffff, 1, 3'b100);
    add_row(enc_rrr(OP_ARITH, 3'd0, 3'd3, SUB_ADD, 3'd3), 0, 1, 3'd0, 16'h0002, 1, 3'b001);
    add_row(enc_rrr(OP_ARITH, 3'd5, 3'd4, SUB_ADD, 3'd3), 0, 1, 3'd5, 16'h0000, 1, 3'b010);
    add_row(enc_br(3'b100, 9'd5),                   0, 0, 3'd0, 16'h0000, 0, 3'b000);
    add_row(enc_br(3'b010, 9'd2),                   0, 0, 3'd0, 16'h0000, 0, 3'b000);
    add_row(enc_const(3'd7, 9'h055),                1, 0, 3'd0, 16'h0000, 0, 3'b000);
    add_row(enc_const(3'd6, 9'h066),                1, 0, 3'd0, 16'h0000, 0, 3'b000);
    add_row(enc_addi(3'd7, 3'd5, 5'd7),             0, 1, 3'd7, 16'h0007, 1, 3'b001);
    add_row(enc_rrr(OP_ARITH, 3'd1, 3'd7, SUB_ADD, 3'd6), 0, 1, 3'd1, 16'h0006, 1, 3'b001);
    add_row(enc_br(3'b111, 9'h1ff),                 0, 0, 3'd0, 16'h0000, 0, 3'b000);  // spin
    for (i = 0; i < prog_len; i++) begin
      imem[i] = prog_insn[i];
      if (!prog_flushed[i])
        u_mon.add_expected(RESET_PC + 16'(i), prog_insn[i], exp_we[i], exp_wsel[i],
                           exp_data[i], exp_nzp_we[i], exp_nzp[i]);
    end
    limit = 4 * prog_len + 20;
    repeat (2) @(posedge gwe);
    i_reset <= 1'b0;
    while (!done && cycles < limit) @(posedge gwe);
    if (!done)
      $display("timeout after %0d cycles, only %0d instructions retired", cycles, retired);
    $display("retired %0d, failed %0d, assertion failures %0d",
             retired, errors, DUT.u_chk.fail_count);
    if (done && errors == 0 && DUT.u_chk.fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
design/lc4_isa_pkg.sv
design/lc4_pipe_pkg.sv
design/lc4_wb_if.sv
design/lc4_fetch.sv
design/lc4_decoder.sv
design/lc4_regfile.sv
design/lc4_execute.sv
design/lc4_mem_wb.sv
design/lc4_processor.sv
testbench/lc4_chk.sv
testbench/lc4_monitor.sv
testbench/tb_lc4.sv
